// File: source/ex_pkg.sv
`default_nettype none

package ex_pkg;

    localparam int EX_PC_WIDTH = 32; // PC width carried in the pipeline words

    typedef enum logic [3:0] {
        op_nop  = 4'd0,
        op_mov  = 4'd1,
        op_add  = 4'd2,
        op_sub  = 4'd3,
        op_and  = 4'd4,
        op_or   = 4'd5,
        op_not  = 4'd6,
        op_inc  = 4'd7,
        op_dec  = 4'd8,
        op_shl  = 4'd9,
        op_shr  = 4'd10,
        op_setc = 4'd11,
        op_clrc = 4'd12
    } alu_op_e;

    typedef enum logic [1:0] {
        src_reg = 2'd0, // Register file read
        src_wb  = 2'd1, // Forward from write-back
        src_mem = 2'd2, // Forward from memory stage
        src_imm = 2'd3  // LDM immediate
    } src_sel_e;

    typedef enum logic [2:0] {
        jmp_none   = 3'd0,
        jmp_always = 3'd1,
        jmp_zero   = 3'd2,
        jmp_neg    = 3'd3,
        jmp_carry  = 3'd4
    } jump_cond_e;

    typedef struct packed {
        logic carry;
        logic negative;
        logic zero;
    } flags_t;

    // Control bits consumed by the memory and write-back stages
    typedef struct packed {
        logic       reg_write;
        logic       pc_enable;
        logic [1:0] wb_sel;
        logic       mem_read;
        logic       mem_write;
        logic       mem_push;
        logic       mem_pop;
        logic [1:0] memory_address_select;
        logic [1:0] memory_write_src_select;
    } ex_ctrl_t;

    typedef struct packed {
        logic [EX_PC_WIDTH-1:0] pc;
        logic [15:0]            read_data1;
        logic [15:0]            read_data2;
        logic [15:0]            ldm_value;
        logic [4:0]             shamt;
        alu_op_e                alu_op;
        src_sel_e               alu_src1_select;
        src_sel_e               alu_src2_select;
        jump_cond_e             jump_cond;
        logic                   flag_update;
        logic                   flag_restore; // Takes priority over flag_update
        ex_ctrl_t               ctrl;
    } ex_in_t;

    typedef struct packed {
        logic [15:0]            result;
        flags_t                 flags;
        logic [EX_PC_WIDTH-1:0] pc;
        logic [EX_PC_WIDTH-1:0] new_pc;
        logic                   branch_taken;
        logic [15:0]            ldm_value;
        logic [15:0]            read_data1;
        logic [15:0]            read_data2;
        ex_ctrl_t               ctrl;
    } ex_out_t;

endpackage

`default_nettype wire

// File: source/operand_select.sv
`timescale 1ns/1ns
`default_nettype none

module operand_select import ex_pkg::*; (
    input  logic [15:0] read_data1,
    input  logic [15:0] read_data2,
    input  logic [15:0] ldm_value,
    input  logic [15:0] write_back_data,
    input  logic [15:0] mem_forward_data,
    input  src_sel_e    alu_src1_select,
    input  src_sel_e    alu_src2_select,
    output logic [15:0] operand_a,
    output logic [15:0] operand_b
);

    // Same four-way choice for both operands, only the register source differs
    function automatic logic [15:0] pick_source(
        input src_sel_e    sel,
        input logic [15:0] reg_value
    );
        logic [15:0] value;
        case (sel)
            src_reg: value = reg_value;
            src_wb:  value = write_back_data;
            src_mem: value = mem_forward_data;
            src_imm: value = ldm_value;
            default: value = reg_value;
        endcase
        return value;
    endfunction

    always_comb begin
        operand_a = pick_source(alu_src1_select, read_data1); // Rdest side
        operand_b = pick_source(alu_src2_select, read_data2); // Rsrc side
    end

endmodule

`default_nettype wire

// File: source/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu import ex_pkg::*; (
    input  alu_op_e     alu_op,
    input  logic [15:0] operand_a,
    input  logic [15:0] operand_b,
    input  logic [4:0]  shamt,
    input  logic        carry_in,
    output logic [15:0] result,
    output flags_t      flags
);

    logic [16:0] sum_wide;   // Bit 16 is carry or borrow
    logic [31:0] shl_wide;
    logic [31:0] shr_wide;
    logic        carry_out;

    // Shift through a double-width word so the shifted-out bit lands next to the result
    assign shl_wide = {16'h0000, operand_a} << shamt;
    assign shr_wide = {operand_a, 16'h0000} >> shamt;

    always_comb begin
        sum_wide = 17'h0_0000;
        case (alu_op)
            op_add:  sum_wide = {1'b0, operand_a} + {1'b0, operand_b};
            op_sub:  sum_wide = {1'b0, operand_a} - {1'b0, operand_b};
            op_inc:  sum_wide = {1'b0, operand_a} + 17'd1;
            op_dec:  sum_wide = {1'b0, operand_a} - 17'd1;
            default: sum_wide = 17'h0_0000;
        endcase
    end

    always_comb begin
        result    = operand_a;
        carry_out = carry_in;
        case (alu_op)
            op_nop: result = operand_a;
            op_mov: result = operand_b;
            op_add, op_sub, op_inc, op_dec: begin
                result    = sum_wide[15:0];
                carry_out = sum_wide[16];
            end
            op_and: result = operand_a & operand_b;
            op_or:  result = operand_a | operand_b;
            op_not: result = ~operand_a;
            op_shl: begin
                result = shl_wide[15:0]; // Zero once shamt reaches 16
                if (shamt != 5'd0) begin
                    carry_out = shl_wide[16];
                end
            end
            op_shr: begin
                result = shr_wide[31:16];
                if (shamt != 5'd0) begin
                    carry_out = shr_wide[15];
                end
            end
            op_setc: carry_out = 1'b1;
            op_clrc: carry_out = 1'b0;
            default: begin
                result    = operand_a;
                carry_out = carry_in;
            end
        endcase
    end

    always_comb begin
        flags.carry    = carry_out;
        flags.negative = result[15];
        flags.zero     = (result == 16'h0000);
    end

endmodule

`default_nettype wire

// File: source/branch_controller.sv
`timescale 1ns/1ns
`default_nettype none

module branch_controller import ex_pkg::*; #(
    parameter int PC_WIDTH = 32
) (
    input  jump_cond_e          jump_cond,
    input  flags_t              flags,
    input  logic [PC_WIDTH-1:0] pc,
    input  logic [15:0]         target,
    output logic                taken,
    output logic [PC_WIDTH-1:0] new_pc
);

    logic [PC_WIDTH-1:0] target_ext;

    assign target_ext = {{(PC_WIDTH-16){1'b0}}, target}; // Zero-extended Rdest

    always_comb begin
        case (jump_cond)
            jmp_none:   taken = 1'b0;
            jmp_always: taken = 1'b1;
            jmp_zero:   taken = flags.zero;
            jmp_neg:    taken = flags.negative;
            jmp_carry:  taken = flags.carry;
            default:    taken = 1'b0;
        endcase
    end

    assign new_pc = taken ? target_ext : pc;

endmodule

`default_nettype wire

// File: source/ex_mem_register.sv
`timescale 1ns/1ns
`default_nettype none

module ex_mem_register import ex_pkg::*; #(
    parameter int PC_WIDTH = 32
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    load,
    input  ex_out_t next_data,
    input  logic    out_ready,
    output logic    out_valid,
    output ex_out_t out_data,
    output logic    in_ready
);

    // Pipeline word carries a fixed-width PC
    if (PC_WIDTH != EX_PC_WIDTH) begin : g_pc_width_check
        $error("ex_mem_register: PC_WIDTH %0d differs from word PC width %0d",
               PC_WIDTH, EX_PC_WIDTH);
    end

    // Free slot, or the held word leaves this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else if (load && in_ready) begin
            out_valid <= 1'b1;
            out_data  <= next_data;
        end else if (out_ready) begin
            out_valid <= 1'b0; // Word taken, nothing new behind it
        end
    end

endmodule

`default_nettype wire

// File: source/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage import ex_pkg::*; #(
    parameter int PC_WIDTH = 32
) (
    input  logic        clk,
    input  logic        rst_n,

    input  logic        in_valid,
    input  ex_in_t      in_data,
    output logic        in_ready,

    input  logic [15:0] write_back_data,
    input  logic [15:0] mem_forward_data,
    input  flags_t      popped_flags,

    output logic        out_valid,
    output ex_out_t     out_data,
    input  logic        out_ready
);

    logic [15:0]         operand_a;
    logic [15:0]         operand_b;
    logic [15:0]         alu_result;
    flags_t              alu_flags;
    flags_t              flag_q;      // Stored CNZ
    flags_t              eff_flags;
    logic                taken;
    logic [PC_WIDTH-1:0] new_pc;
    logic                accept;
    ex_out_t             next_word;

    assign accept = in_valid && in_ready;

    operand_select u_operand_select (
        .read_data1       (in_data.read_data1),
        .read_data2       (in_data.read_data2),
        .ldm_value        (in_data.ldm_value),
        .write_back_data  (write_back_data),
        .mem_forward_data (mem_forward_data),
        .alu_src1_select  (in_data.alu_src1_select),
        .alu_src2_select  (in_data.alu_src2_select),
        .operand_a        (operand_a),
        .operand_b        (operand_b)
    );

    alu u_alu (
        .alu_op    (in_data.alu_op),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .shamt     (in_data.shamt),
        .carry_in  (flag_q.carry),
        .result    (alu_result),
        .flags     (alu_flags)
    );

    // Flags as seen by this instruction, restore from the stack first
    always_comb begin
        if (in_data.flag_restore) begin
            eff_flags = popped_flags;
        end else if (in_data.flag_update) begin
            eff_flags = alu_flags;
        end else begin
            eff_flags = flag_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flag_q <= '0;
        end else if (accept && (in_data.flag_restore || in_data.flag_update)) begin
            flag_q <= eff_flags;
        end
    end

    branch_controller #(
        .PC_WIDTH (PC_WIDTH)
    ) u_branch_controller (
        .jump_cond (in_data.jump_cond),
        .flags     (eff_flags),
        .pc        (in_data.pc),
        .target    (in_data.read_data1),
        .taken     (taken),
        .new_pc    (new_pc)
    );

    always_comb begin
        next_word.result       = alu_result;
        next_word.flags        = eff_flags;
        next_word.pc           = in_data.pc;
        next_word.new_pc       = new_pc;
        next_word.branch_taken = taken;
        next_word.ldm_value    = in_data.ldm_value;
        next_word.read_data1   = in_data.read_data1;
        next_word.read_data2   = in_data.read_data2;
        next_word.ctrl         = in_data.ctrl; // Memory and WB bits pass through
    end

    ex_mem_register #(
        .PC_WIDTH (PC_WIDTH)
    ) u_ex_mem_register (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (in_valid),
        .next_data (next_word),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .in_ready  (in_ready)
    );

endmodule

`default_nettype wire

// File: verification/execute_stage_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage_assertions import ex_pkg::*; (
    input logic    clk,
    input logic    rst_n,
    input logic    in_valid,
    input logic    in_ready,
    input logic    out_valid,
    input logic    out_ready,
    input ex_out_t out_data,
    input flags_t  flag_q
);

    int fail_count = 0;

    // Stalled word must stay put until the memory stage takes it
    hold_while_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
    else begin
        fail_count++;
        $error("out_data changed or out_valid dropped while stalled");
    end

    one_cycle_latency: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && in_ready |=> out_valid)
    else begin
        fail_count++;
        $error("accepted input did not reach the output one cycle later");
    end

    reset_clears: assert property (@(posedge clk)
        !rst_n |=> !out_valid && out_data == '0 && flag_q == '0)
    else begin
        fail_count++;
        $error("reset left out_valid, out_data or the flag register set");
    end

endmodule

bind execute_stage execute_stage_assertions u_assertions (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .flag_q    (flag_q)
);

`default_nettype wire

// File: verification/ex_checker.sv
`timescale 1ns/1ns
`default_nettype none

module ex_checker import ex_pkg::*; (
    input logic    clk,
    input logic    rst_n,
    input logic    out_valid,
    input logic    out_ready,
    input ex_out_t out_data
);

    ex_out_t expected_q[$];
    int      error_count = 0;
    int      match_count = 0;

    function automatic void push_expected(input ex_out_t item);
        expected_q.push_back(item);
    endfunction

    function automatic int pending();
        return expected_q.size();
    endfunction

    function automatic bit compare_field(input string name, input logic [31:0] got,
                                         input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    function automatic void report_leftover();
        if (expected_q.size() != 0) begin
            error_count++;
            $display("%0d accepted items never came out of the stage", expected_q.size());
        end
    endfunction

    // Compare on every output transfer, oldest expected item first
    always @(posedge clk) begin
        ex_out_t exp;
        bit      ok;
        if (rst_n && out_valid && out_ready) begin
            if (expected_q.size() == 0) begin
                error_count++;
                $display("Output transfer at %0t with nothing expected", $time);
            end else begin
                exp = expected_q.pop_front();
                ok  = compare_field("out_data.result", out_data.result, exp.result);
                ok &= compare_field("out_data.flags", out_data.flags, exp.flags);
                ok &= compare_field("out_data.pc", out_data.pc, exp.pc);
                ok &= compare_field("out_data.new_pc", out_data.new_pc, exp.new_pc);
                ok &= compare_field("out_data.branch_taken", out_data.branch_taken,
                                    exp.branch_taken);
                ok &= compare_field("out_data.ldm_value", out_data.ldm_value, exp.ldm_value);
                ok &= compare_field("out_data.read_data1", out_data.read_data1,
                                    exp.read_data1);
                ok &= compare_field("out_data.read_data2", out_data.read_data2,
                                    exp.read_data2);
                ok &= compare_field("out_data.ctrl", out_data.ctrl, exp.ctrl);
                if (ok) begin
                    match_count++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/execute_stage_tb.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage_tb import ex_pkg::*; ();

    localparam int ACCEPT_LIMIT = 50;
    localparam int DRAIN_LIMIT  = 100;
    localparam int RANDOM_ITEMS = 200;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    ex_in_t      in_data;
    logic        in_ready;
    logic [15:0] write_back_data;
    logic [15:0] mem_forward_data;
    flags_t      popped_flags;
    logic        out_valid;
    ex_out_t     out_data;
    logic        out_ready;

    logic        stall_mode;
    flags_t      model_flags;  // Stored CNZ as the model sees it
    int          timeout_errors;
    int          protocol_errors;

    execute_stage #(
        .PC_WIDTH (32)
    ) u_execute_stage (
        .clk              (clk),
        .rst_n            (rst_n),
        .in_valid         (in_valid),
        .in_data          (in_data),
        .in_ready         (in_ready),
        .write_back_data  (write_back_data),
        .mem_forward_data (mem_forward_data),
        .popped_flags     (popped_flags),
        .out_valid        (out_valid),
        .out_data         (out_data),
        .out_ready        (out_ready)
    );

    ex_checker u_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    always #50 clk = ~clk;

    // Memory stage back-pressure
    always @(posedge clk) begin
        #5;
        if (stall_mode) begin
            out_ready = ($urandom_range(0, 2) != 0);
        end else begin
            out_ready = 1'b1;
        end
    end

    function automatic logic [15:0] source_value(input src_sel_e sel,
            input logic [15:0] reg_value, input logic [15:0] imm,
            input logic [15:0] wb_data, input logic [15:0] mem_data);
        case (sel)
            src_wb:  return wb_data;
            src_mem: return mem_data;
            src_imm: return imm;
            default: return reg_value;
        endcase
    endfunction

    function automatic ex_out_t model_execute(input ex_in_t item,
            input logic [15:0] wb_data, input logic [15:0] mem_data,
            input flags_t popped, input flags_t stored);
        ex_out_t     exp;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] r;
        logic        c;
        flags_t      alu_f;
        flags_t      eff;
        int          s;
        a = source_value(item.alu_src1_select, item.read_data1, item.ldm_value,
                         wb_data, mem_data);
        b = source_value(item.alu_src2_select, item.read_data2, item.ldm_value,
                         wb_data, mem_data);
        s = item.shamt;
        r = a;
        c = stored.carry;
        case (item.alu_op)
            op_mov: r = b;
            op_add: {c, r} = {1'b0, a} + {1'b0, b};
            op_sub: begin
                r = a - b;
                c = (a < b); // Borrow
            end
            op_and: r = a & b;
            op_or:  r = a | b;
            op_not: r = ~a;
            op_inc: begin
                r = a + 16'd1;
                c = (a == 16'hffff);
            end
            op_dec: begin
                r = a - 16'd1;
                c = (a == 16'h0000);
            end
            op_shl: if (s != 0) begin
                r = (s >= 16) ? 16'h0000 : (a << s);
                if (s <= 16) c = a[16 - s]; // Last bit pushed out the top
                else c = 1'b0;
            end
            op_shr: if (s != 0) begin
                r = (s >= 16) ? 16'h0000 : (a >> s);
                if (s <= 16) c = a[s - 1];
                else c = 1'b0;
            end
            op_setc: c = 1'b1;
            op_clrc: c = 1'b0;
            default: r = a;
        endcase
        alu_f.carry    = c;
        alu_f.negative = r[15];
        alu_f.zero     = (r == 16'h0000);
        if (item.flag_restore) eff = popped;
        else if (item.flag_update) eff = alu_f;
        else eff = stored;
        case (item.jump_cond)
            jmp_always: exp.branch_taken = 1'b1;
            jmp_zero:   exp.branch_taken = eff.zero;
            jmp_neg:    exp.branch_taken = eff.negative;
            jmp_carry:  exp.branch_taken = eff.carry;
            default:    exp.branch_taken = 1'b0;
        endcase
        exp.result     = r;
        exp.flags      = eff;
        exp.pc         = item.pc;
        exp.new_pc     = exp.branch_taken ? {16'h0000, item.read_data1} : item.pc;
        exp.ldm_value  = item.ldm_value;
        exp.read_data1 = item.read_data1;
        exp.read_data2 = item.read_data2;
        exp.ctrl       = item.ctrl;
        return exp;
    endfunction

    function automatic flags_t random_flags();
        logic [31:0] r;
        r = $urandom;
        return r[2:0];
    endfunction

    function automatic ex_in_t random_item();
        ex_in_t      item;
        logic [31:0] r;
        item.pc              = $urandom;
        r                    = $urandom;
        item.read_data1      = r[15:0];
        item.read_data2      = r[31:16];
        r                    = $urandom;
        item.ldm_value       = r[15:0];
        item.shamt           = r[20:16]; // Half of these are 16 or more
        item.ctrl            = r[31:20];
        item.alu_op          = alu_op_e'($urandom_range(0, 12));
        item.alu_src1_select = src_sel_e'($urandom_range(0, 3));
        item.alu_src2_select = src_sel_e'($urandom_range(0, 3));
        item.jump_cond       = jump_cond_e'($urandom_range(0, 4));
        item.flag_update     = $urandom_range(0, 1);
        item.flag_restore    = ($urandom_range(0, 7) == 0);
        return item;
    endfunction

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            protocol_errors++;
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // Present one instruction until the stage accepts it, then model it
    task automatic send_item(input ex_in_t item, input flags_t popped);
        logic [31:0] r;
        ex_out_t     exp;
        int          waited;
        r                = $urandom;
        in_valid         = 1'b1;
        in_data          = item;
        write_back_data  = r[15:0];
        mem_forward_data = r[31:16];
        popped_flags     = popped;
        waited           = 0;
        @(posedge clk);
        while (!in_ready && waited < ACCEPT_LIMIT) begin
            waited++;
            @(posedge clk);
        end
        if (in_ready) begin
            exp = model_execute(item, r[15:0], r[31:16], popped, model_flags);
            u_checker.push_expected(exp);
            if (item.flag_restore || item.flag_update) model_flags = exp.flags;
        end else begin
            timeout_errors++;
            $display("Timed out at %0t waiting for in_ready", $time);
        end
        #5;
        in_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) @(posedge clk);
        #5;
    endtask

    initial begin
        ex_in_t item;
        int     waited;
        int     total;
        void'($urandom(32'h1bea_f260));
        clk              = 1'b0;
        rst_n            = 1'b0;
        in_valid         = 1'b0;
        in_data          = '0;
        write_back_data  = 16'h0000;
        mem_forward_data = 16'h0000;
        popped_flags     = '0;
        out_ready        = 1'b1;
        stall_mode       = 1'b0;
        model_flags      = '0;
        timeout_errors   = 0;
        protocol_errors  = 0;
        repeat (8) @(posedge clk);
        #5;
        rst_n = 1'b1;
        check_level("out_valid", out_valid, 1'b0);
        check_level("in_ready", in_ready, 1'b1);

        // First flag writer keeps the cleared carry, then an add with carry out
        item = random_item();
        item.alu_op       = op_and;
        item.flag_update  = 1'b1;
        item.flag_restore = 1'b0;
        send_item(item, random_flags());
        item = random_item();
        item.alu_op          = op_add;
        item.alu_src1_select = src_reg;
        item.alu_src2_select = src_reg;
        item.read_data1      = 16'hffff;
        item.read_data2      = 16'h0001;
        item.flag_update     = 1'b1;
        item.flag_restore    = 1'b0;
        send_item(item, random_flags());

        stall_mode = 1'b1;
        for (int i = 0; i < RANDOM_ITEMS; i++) begin
            send_item(random_item(), random_flags());
            if ($urandom_range(0, 3) == 0) idle_cycles($urandom_range(1, 3));
        end

        // Restored carry steers the following jump-if-carry
        for (int carry = 0; carry < 2; carry++) begin
            item = random_item();
            item.flag_restore = 1'b1;
            item.jump_cond    = jmp_none;
            send_item(item, {carry[0], 2'b01});
            item = random_item();
            item.flag_restore = 1'b0;
            item.flag_update  = 1'b0;
            item.jump_cond    = jmp_carry;
            send_item(item, random_flags());
        end

        for (int cond = 0; cond < 5; cond++) begin
            for (int upd = 0; upd < 2; upd++) begin
                item = random_item();
                item.jump_cond    = jump_cond_e'(cond);
                item.flag_update  = upd[0];
                item.flag_restore = 1'b0;
                send_item(item, random_flags());
            end
        end

        stall_mode = 1'b0;
        waited     = 0;
        while (u_checker.pending() != 0 && waited < DRAIN_LIMIT) begin
            waited++;
            @(posedge clk);
        end
        if (u_checker.pending() != 0) begin
            timeout_errors++;
            $display("Timed out draining the output, %0d items still queued",
                     u_checker.pending());
        end
        idle_cycles(2);
        u_checker.report_leftover();

        total = u_checker.error_count + protocol_errors + timeout_errors
              + u_execute_stage.u_assertions.fail_count;
        $display("Errors: checker %0d, protocol %0d, timeout %0d, assertion %0d, matched %0d",
                 u_checker.error_count, protocol_errors, timeout_errors,
                 u_execute_stage.u_assertions.fail_count, u_checker.match_count);
        if (total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
source/ex_pkg.sv
source/operand_select.sv
source/alu.sv
source/branch_controller.sv
source/ex_mem_register.sv
source/execute_stage.sv
verification/execute_stage_assertions.sv
verification/ex_checker.sv
verification/execute_stage_tb.sv
